// ==== all.f ====
+incdir+src
src/rsa_pkg.sv
src/bank_if.sv
src/temp_bank.sv
src/stage_sequencer.sv
src/operand_skew.sv
src/pe_mac.sv
src/pe_array.sv
src/rsa_top.sv
bench/rsa_sva.sv
bench/tb_rsa.sv

// ==== bench/rsa_sva.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rsa_cfg.svh"

module rsa_sva (
  input logic clk,
  input logic i_rst_n,
  input logic i_stage_val,
  input logic o_stage_rdy,
  input logic o_done,
  input logic i_host_wr,
  input logic i_host_rd,
  input logic o_rd_val
);

  // LOAD_M, FEED, STORE_C, read latency and drain
  localparam int STAGE_CYCLES = 3 * `RSA_WORDS + 1 + `RSA_DRAIN_CYCLES;

  logic start;
  logic rd_ok;
  logic busy_q;
  int   since_start_q;

  assign start = i_stage_val && o_stage_rdy;
  // reads only count while idle, a write masks them
  assign rd_ok = i_host_rd && !i_host_wr && o_stage_rdy;

  // cycles since the accepted start
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      busy_q        <= 1'b0;
      since_start_q <= 0;
    end else if (start) begin
      busy_q        <= 1'b1;
      since_start_q <= 1;
    end else if (o_done) begin
      busy_q        <= 1'b0;
      since_start_q <= 0;
    end else if (busy_q) begin
      since_start_q <= since_start_q + 1;
    end
  end

  a_reset_idle: assert property (@(posedge clk)
    $rose(i_rst_n) |-> (o_stage_rdy && !o_done && !o_rd_val))
    else $error("stage and host outputs not idle after reset");

  // ready stays low for the whole stage
  a_busy_not_rdy: assert property (@(posedge clk) disable iff (!i_rst_n)
    busy_q |-> !o_stage_rdy)
    else $error("stage ready high while a stage runs");

  // one done per start, at the fixed latency
  a_done_once: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_done |-> (busy_q && (since_start_q == STAGE_CYCLES)))
    else $error("done without a running stage or at the wrong cycle");

  a_done_bound: assert property (@(posedge clk) disable iff (!i_rst_n)
    busy_q |-> (since_start_q <= STAGE_CYCLES))
    else $error("stage ran past its latency without done");

  a_rdy_after_done: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_done |=> o_stage_rdy)
    else $error("stage ready did not return after done");

  a_rd_val_follows: assert property (@(posedge clk) disable iff (!i_rst_n)
    rd_ok |=> o_rd_val)
    else $error("read valid missing one cycle after a read");

  a_rd_val_cause: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_rd_val |-> $past(rd_ok))
    else $error("read valid without a serviced read");

endmodule

bind rsa_top rsa_sva u_sva (
  .clk         (clk),
  .i_rst_n     (i_rst_n),
  .i_stage_val (i_stage_val),
  .o_stage_rdy (o_stage_rdy),
  .o_done      (o_done),
  .i_host_wr   (i_host_wr),
  .i_host_rd   (i_host_rd),
  .o_rd_val    (o_rd_val)
);

`default_nettype wire

// ==== bench/tb_rsa.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rsa_cfg.svh"

module tb_rsa import rsa_pkg::*; ();

  localparam int HOST_DEPTH = 4 * `RSA_WORDS * `RSA_N;
  localparam int WAIT_LIMIT = 100;

  logic        clk;
  logic        i_rst_n;
  logic        i_stage_val;
  logic        o_stage_rdy;
  logic        o_done;
  logic        i_host_wr;
  logic        i_host_rd;
  host_addr_t  i_host_addr;
  elem_t       i_host_wdata;
  elem_t       o_rd_data;
  logic        o_rd_val;

  // expected bank contents by host address
  elem_t       shadow [0:HOST_DEPTH-1];
  logic [31:0] lfsr_q;
  int          value_errors;
  int          timeout_errors;

  rsa_top u_dut (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_stage_val  (i_stage_val),
    .o_stage_rdy  (o_stage_rdy),
    .o_done       (o_done),
    .i_host_wr    (i_host_wr),
    .i_host_rd    (i_host_rd),
    .i_host_addr  (i_host_addr),
    .i_host_wdata (i_host_wdata),
    .o_rd_data    (o_rd_data),
    .o_rd_val     (o_rd_val)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic next_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic elem_t rand_elem();
    elem_t v;
    v = '0;
    for (int b = 0; b < `RSA_DW; b++) begin
      v = {v[`RSA_DW-2:0], next_bit()};
    end
    return v;
  endfunction

  // {region, word, lane}
  function automatic host_addr_t make_addr(logic [1:0] region, int word, int lane);
    return {region, word[1:0], lane[1:0]};
  endfunction

  // C[r][j] = M[r][j] + sum of A[r][k] * B[k][j], kept to 16 bits
  function automatic elem_t model_c(int r, int j);
    int sum;
    sum = int'(shadow[make_addr(`RSA_REGION_M, r, j)]);
    for (int k = 0; k < `RSA_N; k++) begin
      sum += int'(shadow[make_addr(`RSA_REGION_A, k, r)]) *
             int'(shadow[make_addr(`RSA_REGION_B, k, j)]);
    end
    return elem_t'(sum[`RSA_DW-1:0]);
  endfunction

  task automatic check_elem(input string what, input elem_t got, input elem_t exp);
    value_check: assert (got === exp) else begin
      $display("FAIL %0t %s: got %h, expected %h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic host_write(input host_addr_t addr, input elem_t data);
    @(posedge clk);
    i_host_wr    <= 1'b1;
    i_host_addr  <= addr;
    i_host_wdata <= data;
    @(posedge clk);
    i_host_wr    <= 1'b0;
    shadow[addr] = data;
  endtask

  task automatic host_read(input host_addr_t addr, output elem_t data);
    int waited;
    @(posedge clk);
    i_host_rd   <= 1'b1;
    i_host_addr <= addr;
    @(posedge clk);
    i_host_rd <= 1'b0;
    waited = 0;
    // outputs sampled on the falling edge
    do begin
      @(negedge clk);
      waited++;
    end while (!o_rd_val && (waited < WAIT_LIMIT));
    data = o_rd_data;
    if (!o_rd_val) begin
      $display("timeout: no read data came back for host address %0d", addr);
      timeout_errors++;
    end else begin
      rd_latency: assert (waited == 1) else begin
        $display("FAIL %0t read of address %0d took %0d cycles", $time, addr, waited);
        value_errors++;
      end
    end
  endtask

  // val held high until done, so the stage runs exactly once
  task automatic run_stage();
    int   waited;
    logic seen;
    @(posedge clk);
    i_stage_val <= 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!o_done && (waited < WAIT_LIMIT));
    seen = o_done;
    @(posedge clk);
    i_stage_val <= 1'b0;
    if (!seen) begin
      $display("timeout: stage never signalled done after %0d cycles", waited);
      timeout_errors++;
    end
  endtask

  initial begin
    elem_t got;
    lfsr_q         = 32'h3adb8f10;
    value_errors   = 0;
    timeout_errors = 0;
    i_rst_n      <= 1'b0;
    i_stage_val  <= 1'b0;
    i_host_wr    <= 1'b0;
    i_host_rd    <= 1'b0;
    i_host_addr  <= '0;
    i_host_wdata <= '0;
    repeat (5) @(posedge clk);
    i_rst_n <= 1'b1;

    // every host address, random fill then readback
    for (int a = 0; a < HOST_DEPTH; a++) begin
      host_write(host_addr_t'(a), rand_elem());
    end
    for (int a = 0; a < HOST_DEPTH; a++) begin
      host_read(host_addr_t'(a), got);
      check_elem($sformatf("readback of address %0d", a), got, shadow[a]);
    end

    // stage on the random A, B and M
    run_stage();
    for (int r = 0; r < `RSA_N; r++) begin
      for (int j = 0; j < `RSA_N; j++) begin
        host_read(make_addr(`RSA_REGION_C, r, j), got);
        check_elem($sformatf("C[%0d][%0d] of random stage", r, j), got, model_c(r, j));
      end
    end

    // M zero and B identity, A left as it is
    for (int r = 0; r < `RSA_N; r++) begin
      for (int j = 0; j < `RSA_N; j++) begin
        host_write(make_addr(`RSA_REGION_M, r, j), '0);
        host_write(make_addr(`RSA_REGION_B, r, j), (r == j) ? elem_t'(1) : elem_t'(0));
      end
    end
    run_stage();
    // C[r][j] against A[r][j], which sits in word j lane r
    for (int r = 0; r < `RSA_N; r++) begin
      for (int j = 0; j < `RSA_N; j++) begin
        host_read(make_addr(`RSA_REGION_C, r, j), got);
        check_elem($sformatf("C[%0d][%0d] of identity stage", r, j), got,
                   shadow[make_addr(`RSA_REGION_A, j, r)]);
      end
    end

    @(posedge clk);
    $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if ((value_errors == 0) && (timeout_errors == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rsa testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_rsa -Mdir obj_dir -f all.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_rsa)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

// ==== src/bank_if.sv ====
`default_nettype none
`timescale 1ns/10ps

// one port of the temporary bank
interface bank_if import rsa_pkg::*; ();

  // request side
  logic       en;
  lane_mask_t we;
  word_addr_t addr;
  row_t       wdata;

  // read data, valid one cycle after a read request
  row_t       rdata;

  // sequencer side
  modport master (
    output en, we, addr, wdata,
    input  rdata
  );

  // storage side
  modport bank (
    input  en, we, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

// ==== src/operand_skew.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rsa_cfg.svh"

module operand_skew import rsa_pkg::*; (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_val,
  input  row_t             i_row,
  output row_t             o_row,
  output logic [`RSA_N-1:0] o_val
);

  // staircase, lane n is n+1 registers deep
  for (genvar n = 0; n < `RSA_N; n++) begin : g_lane
    elem_t      dly_q [0:n];
    logic [n:0] vld_q;

    // data chain
    always_ff @(posedge clk) begin
      dly_q[0] <= i_row[n];
      for (int s = 1; s <= n; s++) begin
        dly_q[s] <= dly_q[s-1];
      end
    end

    // valid travels with its element
    always_ff @(posedge clk) begin
      if (!i_rst_n) begin
        vld_q <= '0;
      end else begin
        vld_q[0] <= i_val;
        for (int s = 1; s <= n; s++) begin
          vld_q[s] <= vld_q[s-1];
        end
      end
    end

    assign o_row[n] = dly_q[n];
    assign o_val[n] = vld_q[n];
  end

endmodule

`default_nettype wire

// ==== src/pe_array.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rsa_cfg.svh"

module pe_array import rsa_pkg::*; (
  input  logic              clk,
  input  logic              i_rst_n,
  // accumulator preload, one row per cycle
  input  logic              i_acc_load,
  input  row_sel_t          i_row_sel,
  input  row_t              i_m_row,
  // skewed operands, A from the west and B from the south
  input  row_t              i_west,
  input  logic [`RSA_N-1:0] i_west_val,
  input  row_t              i_south,
  input  logic [`RSA_N-1:0] i_south_val,
  // accumulators of row i_row_sel
  output row_t              o_c_row
);

  // west_d[i][j] feeds cell (i,j) from its west side
  elem_t west_d [0:`RSA_N-1][0:`RSA_N];
  logic  west_v [0:`RSA_N-1][0:`RSA_N];
  // south_d[i][j] feeds cell (i,j) from below
  elem_t south_d [0:`RSA_N][0:`RSA_N-1];
  logic  south_v [0:`RSA_N][0:`RSA_N-1];
  elem_t acc [0:`RSA_N-1][0:`RSA_N-1];

  for (genvar i = 0; i < `RSA_N; i++) begin : g_row
    // array edges
    assign west_d[i][0]  = i_west[i];
    assign west_v[i][0]  = i_west_val[i];
    assign south_d[0][i] = i_south[i];
    assign south_v[0][i] = i_south_val[i];

    for (genvar j = 0; j < `RSA_N; j++) begin : g_col
      pe_mac u_pe (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_load      (i_acc_load && (i_row_sel == row_sel_t'(i))),
        .i_load_val  (i_m_row[j]),
        .i_west      (west_d[i][j]),
        .i_west_val  (west_v[i][j]),
        .i_south     (south_d[i][j]),
        .i_south_val (south_v[i][j]),
        .o_east      (west_d[i][j+1]),
        .o_east_val  (west_v[i][j+1]),
        .o_north     (south_d[i+1][j]),
        .o_north_val (south_v[i+1][j]),
        .o_acc       (acc[i][j])
      );
    end

    // readout mux, column i of the selected row
    assign o_c_row[i] = acc[i_row_sel][i];
  end

endmodule

`default_nettype wire

// ==== src/pe_mac.sv ====
`default_nettype none
`timescale 1ns/10ps

module pe_mac import rsa_pkg::*; (
  input  logic  clk,
  input  logic  i_rst_n,
  // accumulator preload
  input  logic  i_load,
  input  elem_t i_load_val,
  // operands in
  input  elem_t i_west,
  input  logic  i_west_val,
  input  elem_t i_south,
  input  logic  i_south_val,
  // operands out, one cycle later
  output elem_t o_east,
  output logic  o_east_val,
  output elem_t o_north,
  output logic  o_north_val,
  output elem_t o_acc
);

  elem_t acc_q;

  // preload wins over accumulate
  // product is cut to 16 bits, so the sum wraps
  always_ff @(posedge clk) begin
    if (i_load) begin
      acc_q <= i_load_val;
    end else if (i_west_val && i_south_val) begin
      acc_q <= acc_q + i_west * i_south;
    end
  end

  // operand forwarding
  always_ff @(posedge clk) begin
    o_east  <= i_west;
    o_north <= i_south;
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_east_val  <= 1'b0;
      o_north_val <= 1'b0;
    end else begin
      o_east_val  <= i_west_val;
      o_north_val <= i_south_val;
    end
  end

  assign o_acc = acc_q;

endmodule

`default_nettype wire

// ==== src/rsa_cfg.svh ====
`ifndef RSA_CFG_SVH
`define RSA_CFG_SVH

// array edge size and number of bank lanes
`define RSA_N 4

// element width in bits
`define RSA_DW 16

// words in each bank region
`define RSA_WORDS 4

// region codes in the upper two bits of a word address
`define RSA_REGION_A 2'd0
`define RSA_REGION_B 2'd1
`define RSA_REGION_M 2'd2
`define RSA_REGION_C 2'd3

// cycles after the last feed until the far corner cell has accumulated
`define RSA_DRAIN_CYCLES (2 * (`RSA_N - 1) + 1)

`endif

// ==== src/rsa_pkg.sv ====
`default_nettype none

`include "rsa_cfg.svh"

package rsa_pkg;

  // one array element, wraps modulo 2^16
  typedef logic signed [`RSA_DW-1:0] elem_t;

  // one bank word, lane n holds element n
  typedef elem_t [`RSA_N-1:0] row_t;

  // {region, word}
  typedef logic [$clog2(4 * `RSA_WORDS)-1:0] word_addr_t;

  // {region, word, lane}
  typedef logic [$clog2(4 * `RSA_WORDS * `RSA_N)-1:0] host_addr_t;

  typedef logic [`RSA_N-1:0] lane_mask_t;

  typedef logic [$clog2(`RSA_N)-1:0] row_sel_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_M,
    FEED,
    DRAIN,
    STORE_C
  } seq_state_e;

endpackage

`default_nettype wire

// ==== src/rsa_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module rsa_top import rsa_pkg::*; (
  input  logic       clk,
  input  logic       i_rst_n,
  // stage handshake
  input  logic       i_stage_val,
  output logic       o_stage_rdy,
  output logic       o_done,
  // host request port
  input  logic       i_host_wr,
  input  logic       i_host_rd,
  input  host_addr_t i_host_addr,
  input  elem_t      i_host_wdata,
  output elem_t      o_rd_data,
  output logic       o_rd_val
);

  // port a: host, M preload, A feed
  // port b: B feed, C store
  bank_if port_a ();
  bank_if port_b ();

  logic                    feed_val;
  logic                    acc_load;
  row_sel_t                row_sel;
  row_t                    c_row;
  row_t                    west_row;
  row_t                    south_row;
  logic [$bits(row_t)/$bits(elem_t)-1:0] west_val;
  logic [$bits(row_t)/$bits(elem_t)-1:0] south_val;
  row_sel_t                rd_lane_q;

  temp_bank u_bank (
    .clk    (clk),
    .port_a (port_a),
    .port_b (port_b)
  );

  stage_sequencer u_seq (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_stage_val  (i_stage_val),
    .o_stage_rdy  (o_stage_rdy),
    .o_done       (o_done),
    .i_host_wr    (i_host_wr),
    .i_host_rd    (i_host_rd),
    .i_host_addr  (i_host_addr),
    .i_host_wdata (i_host_wdata),
    .o_rd_val     (o_rd_val),
    .i_c_row      (c_row),
    .o_feed_val   (feed_val),
    .o_acc_load   (acc_load),
    .o_row_sel    (row_sel),
    .port_a       (port_a),
    .port_b       (port_b)
  );

  // west edge takes A columns
  operand_skew u_skew_a (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_val   (feed_val),
    .i_row   (port_a.rdata),
    .o_row   (west_row),
    .o_val   (west_val)
  );

  // south edge takes B rows
  operand_skew u_skew_b (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_val   (feed_val),
    .i_row   (port_b.rdata),
    .o_row   (south_row),
    .o_val   (south_val)
  );

  // M words arrive on port a during preload
  pe_array u_array (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_acc_load  (acc_load),
    .i_row_sel   (row_sel),
    .i_m_row     (port_a.rdata),
    .i_west      (west_row),
    .i_west_val  (west_val),
    .i_south     (south_row),
    .i_south_val (south_val),
    .o_c_row     (c_row)
  );

  // lane of the host read, lined up with the bank latency
  always_ff @(posedge clk) begin
    rd_lane_q <= i_host_addr[$bits(row_sel_t)-1:0];
  end

  assign o_rd_data = port_a.rdata[rd_lane_q];

endmodule

`default_nettype wire

// ==== src/stage_sequencer.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rsa_cfg.svh"

module stage_sequencer import rsa_pkg::*; (
  input  logic       clk,
  input  logic       i_rst_n,
  // stage handshake
  input  logic       i_stage_val,
  output logic       o_stage_rdy,
  output logic       o_done,
  // host request port
  input  logic       i_host_wr,
  input  logic       i_host_rd,
  input  host_addr_t i_host_addr,
  input  elem_t      i_host_wdata,
  output logic       o_rd_val,
  // array control
  input  row_t       i_c_row,
  output logic       o_feed_val,
  output logic       o_acc_load,
  output row_sel_t   o_row_sel,
  // bank ports
  bank_if.master     port_a,
  bank_if.master     port_b
);

  localparam int DRAIN_W = $clog2(`RSA_DRAIN_CYCLES + 1);

  seq_state_e         state_q;
  row_sel_t           cnt_q;
  logic [DRAIN_W-1:0] drain_q;
  logic               cnt_last;
  logic               host_wr_ok;
  logic               host_rd_ok;
  row_sel_t           load_row_q;
  row_sel_t           host_lane;
  word_addr_t         host_word;

  assign cnt_last    = (cnt_q == row_sel_t'(`RSA_WORDS - 1));
  assign o_stage_rdy = (state_q == IDLE);
  // last C row goes into the bank on this edge
  assign o_done      = (state_q == STORE_C) && cnt_last;

  // host only gets the bank while idle, write wins over read
  assign host_wr_ok = o_stage_rdy && i_host_wr;
  assign host_rd_ok = o_stage_rdy && i_host_rd && !i_host_wr;
  assign host_lane  = i_host_addr[$bits(row_sel_t)-1:0];
  assign host_word  = i_host_addr[$bits(host_addr_t)-1 -: $bits(word_addr_t)];

  // main FSM
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      drain_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          cnt_q <= '0;
          if (i_stage_val) begin
            state_q <= LOAD_M;
          end
        end
        LOAD_M: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_last) begin
            state_q <= FEED;
          end
        end
        FEED: begin
          cnt_q   <= cnt_q + 1'b1;
          drain_q <= '0;
          if (cnt_last) begin
            state_q <= DRAIN;
          end
        end
        DRAIN: begin
          // first cycle covers the read latency of the last feed word
          drain_q <= drain_q + 1'b1;
          if (drain_q == DRAIN_W'(`RSA_DRAIN_CYCLES)) begin
            state_q <= STORE_C;
          end
        end
        STORE_C: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_last) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // bank data shows up one cycle after the read
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_feed_val <= 1'b0;
      o_acc_load <= 1'b0;
      o_rd_val   <= 1'b0;
    end else begin
      o_feed_val <= (state_q == FEED);
      o_acc_load <= (state_q == LOAD_M);
      o_rd_val   <= host_rd_ok;
    end
  end

  // row that the returning M word belongs to
  always_ff @(posedge clk) begin
    load_row_q <= cnt_q;
  end

  // preload row while loading, readout row while storing
  assign o_row_sel = o_acc_load ? load_row_q : cnt_q;

  // bank port requests
  always_comb begin
    port_a.en    = 1'b0;
    port_a.we    = '0;
    port_a.addr  = '0;
    port_a.wdata = '0;
    port_b.en    = 1'b0;
    port_b.we    = '0;
    port_b.addr  = '0;
    port_b.wdata = '0;
    case (state_q)
      IDLE: begin
        if (host_wr_ok || host_rd_ok) begin
          port_a.en   = 1'b1;
          port_a.addr = host_word;
        end
        if (host_wr_ok) begin
          // element on every lane, mask picks the one lane
          port_a.we    = lane_mask_t'(1) << host_lane;
          port_a.wdata = {`RSA_N{i_host_wdata}};
        end
      end
      LOAD_M: begin
        port_a.en   = 1'b1;
        port_a.addr = {`RSA_REGION_M, cnt_q};
      end
      FEED: begin
        // column k of A and row k of B
        port_a.en   = 1'b1;
        port_a.addr = {`RSA_REGION_A, cnt_q};
        port_b.en   = 1'b1;
        port_b.addr = {`RSA_REGION_B, cnt_q};
      end
      STORE_C: begin
        port_b.en    = 1'b1;
        port_b.we    = '1;
        port_b.addr  = {`RSA_REGION_C, cnt_q};
        port_b.wdata = i_c_row;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/temp_bank.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rsa_cfg.svh"

module temp_bank import rsa_pkg::*; (
  input  logic clk,
  bank_if.bank port_a,
  bank_if.bank port_b
);

  localparam int DEPTH = 4 * `RSA_WORDS;

  // four regions of RSA_WORDS rows each
  row_t mem [0:DEPTH-1];

  // both ports in one process so the array has a single writer
  // port b lands last on a same-word collision, which the sequencer never issues
  always_ff @(posedge clk) begin
    // port a, per-lane masked write
    for (int l = 0; l < `RSA_N; l++) begin
      if (port_a.en && port_a.we[l]) begin
        mem[port_a.addr][l] <= port_a.wdata[l];
      end
    end
    // port b, per-lane masked write
    for (int l = 0; l < `RSA_N; l++) begin
      if (port_b.en && port_b.we[l]) begin
        mem[port_b.addr][l] <= port_b.wdata[l];
      end
    end
  end

  // synchronous reads
  // rdata holds its last value between reads
  always_ff @(posedge clk) begin
    if (port_a.en && (port_a.we == '0)) begin
      port_a.rdata <= mem[port_a.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (port_b.en && (port_b.we == '0)) begin
      port_b.rdata <= mem[port_b.addr];
    end
  end

endmodule

`default_nettype wire
